// File: build.f
+incdir+include
verilog/mem_pkg.sv
verilog/mem_if.sv
verilog/cfg_loader.sv
verilog/host_mmio.sv
verilog/dram_model.sv
verilog/mmio_router.sv
verilog/mem_harness_top.sv
verif/mem_harness_sva.sv
verif/mem_harness_tb.sv

// File: include/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Bus widths
`define MEM_ADDR_WIDTH    32
`define MEM_DATA_WIDTH    64

// Address map, host below the DRAM base
`define DRAM_BASE_ADDR    32'h8000_0000
`define HOST_SCRATCH_ADDR 32'h0000_0000
`define HOST_FINISH_ADDR  32'h0000_0008

// DRAM geometry and latency
`define DRAM_WORDS        256
`define DRAM_IDX_WIDTH    8
`define DRAM_LATENCY      4

// Loader and router sizing
`define RESET_DELAY       10
`define CFG_WORDS         4
`define CFG_PATTERN       64'hC0DE_0000_0000_1000
`define ORDER_DEPTH       4

`endif

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mem_harness_tb \
  -f build.f -Mdir obj_dir -o mem_harness_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/mem_harness_sim 2>&1)
run_status=$?
printf '%s\n' "$output"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: verif/mem_harness_sva.sv
`timescale 1ns/1ps

module mem_harness_sva
  (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               resp_v_o,
    input  logic               resp_we_o,
    input  mem_pkg::mem_data_t resp_data_o,
    input  logic               resp_ready_i,
    input  logic               cmd_ready_o,
    input  logic               cfg_done_o
  );

  // Stalled response keeps its contents
  property resp_hold_p;
    @(posedge clk_i) disable iff (!arst_n_i)
      (resp_v_o && !resp_ready_i) |=>
        (resp_v_o && $stable(resp_data_o) && $stable(resp_we_o));
  endproperty

  resp_hold_a: assert property (resp_hold_p)
    else $error("response dropped or changed while resp_ready_i was low");

  // External port closed during config
  cmd_closed_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !cfg_done_o |-> !cmd_ready_o)
    else $error("cmd_ready_o high before cfg_done_o");

  cfg_done_sticky_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cfg_done_o |=> cfg_done_o)
    else $error("cfg_done_o fell after rising");

endmodule

bind mem_harness_top mem_harness_sva u_sva
(
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .resp_v_o     (resp_v_o),
  .resp_we_o    (resp_we_o),
  .resp_data_o  (resp_data_o),
  .resp_ready_i (resp_ready_i),
  .cmd_ready_o  (cmd_ready_o),
  .cfg_done_o   (cfg_done_o)
);

// File: verif/mem_harness_tb.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_harness_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int ISSUE_SAMPLE = 5;
  localparam int RESP_SAMPLE  = 15;
  localparam int RAND_OPS     = 24;

  typedef struct packed
  {
    logic               we;
    mem_pkg::mem_addr_t addr;
    mem_pkg::mem_data_t data;
    mem_pkg::mem_data_t exp;
  } entry_t;

  logic               clk_i;
  logic               arst_n_i;
  logic               cmd_v_i;
  logic               cmd_we_i;
  mem_pkg::mem_addr_t cmd_addr_i;
  mem_pkg::mem_data_t cmd_data_i;
  logic               cmd_ready_o;
  logic               resp_v_o;
  logic               resp_we_o;
  mem_pkg::mem_data_t resp_data_o;
  logic               resp_ready_i;
  logic               cfg_done_o;
  logic               program_finish_o;

  entry_t             tbl [$];
  mem_pkg::mem_data_t dram_ref [`DRAM_WORDS];
  mem_pkg::mem_data_t scratch_ref;
  logic               finish_ref;
  int                 seed = 32'h32817465;
  int                 issued;

  mem_harness_top DUT
  (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .cmd_v_i          (cmd_v_i),
    .cmd_we_i         (cmd_we_i),
    .cmd_addr_i       (cmd_addr_i),
    .cmd_data_i       (cmd_data_i),
    .cmd_ready_o      (cmd_ready_o),
    .resp_v_o         (resp_v_o),
    .resp_we_o        (resp_we_o),
    .resp_data_o      (resp_data_o),
    .resp_ready_i     (resp_ready_i),
    .cfg_done_o       (cfg_done_o),
    .program_finish_o (program_finish_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Word offset from the base, wrapped by the depth
  function automatic mem_pkg::dram_idx_t word_index(input mem_pkg::mem_addr_t addr);
    mem_pkg::mem_addr_t off;
    off = addr - `DRAM_BASE_ADDR;
    return mem_pkg::dram_idx_t'((off >> 3) % `DRAM_WORDS);
  endfunction

  // Reference model step, also yields the expected response data
  function automatic void add_entry(input logic we, input mem_pkg::mem_addr_t addr,
                                    input mem_pkg::mem_data_t data);
    entry_t e;
    e.we   = we;
    e.addr = addr;
    e.data = data;
    e.exp  = '0;
    if (addr >= `DRAM_BASE_ADDR)
    begin
      if (we)
        dram_ref[word_index(addr)] = data;
      else
        e.exp = dram_ref[word_index(addr)];
    end
    else if (addr == `HOST_SCRATCH_ADDR)
    begin
      if (we)
        scratch_ref = data;
      else
        e.exp = scratch_ref;
    end
    else if (addr == `HOST_FINISH_ADDR)
    begin
      if (we)
        finish_ref = 1'b1;
      else
        e.exp = mem_pkg::mem_data_t'(finish_ref);
    end
    tbl.push_back(e);
  endfunction

  task automatic build_table();
    logic [31:0]        r;
    mem_pkg::mem_addr_t off;
    mem_pkg::mem_addr_t addr;
    mem_pkg::mem_data_t data;
    // State left behind by the config loader
    for (int k = 0; k < `CFG_WORDS; k++)
    begin
      dram_ref[mem_pkg::dram_idx_t'(k)] = `CFG_PATTERN + mem_pkg::mem_data_t'(k);
    end
    scratch_ref = `CFG_PATTERN;
    finish_ref  = 1'b0;
    for (int k = 0; k < `CFG_WORDS; k++)
    begin
      add_entry(1'b0, `DRAM_BASE_ADDR + mem_pkg::mem_addr_t'(8 * k), '0);
    end
    add_entry(1'b0, `HOST_SCRATCH_ADDR, '0);
    for (int k = 4; k < 8; k++)
    begin
      add_entry(1'b1, `DRAM_BASE_ADDR + mem_pkg::mem_addr_t'(8 * k),
                64'h1111_0000_0000_0000 + mem_pkg::mem_data_t'(k));
    end
    add_entry(1'b1, `DRAM_BASE_ADDR + 32'h100, 64'hA5A5_0000_DEAD_0020);
    add_entry(1'b1, `DRAM_BASE_ADDR + 32'h7F8, 64'h5A5A_0000_BEEF_00FF);
    for (int k = 4; k < 8; k++)
    begin
      add_entry(1'b0, `DRAM_BASE_ADDR + mem_pkg::mem_addr_t'(8 * k), '0);
    end
    add_entry(1'b0, `DRAM_BASE_ADDR + 32'h100, '0);
    add_entry(1'b0, `DRAM_BASE_ADDR + 32'h7F8, '0);
    // Past the top of the array, lands on word 2
    add_entry(1'b1, `DRAM_BASE_ADDR + 32'h810, 64'h0123_4567_89AB_CDEF);
    add_entry(1'b0, `DRAM_BASE_ADDR + 32'h010, '0);
    add_entry(1'b1, `HOST_SCRATCH_ADDR, 64'hFEED_FACE_0000_0042);
    add_entry(1'b0, `HOST_SCRATCH_ADDR, '0);
    add_entry(1'b0, 32'h0000_0010, '0);
    add_entry(1'b0, `HOST_FINISH_ADDR, '0);
    add_entry(1'b1, `HOST_FINISH_ADDR, 64'h1);
    add_entry(1'b0, `HOST_FINISH_ADDR, '0);
    // Host and DRAM interleaved
    add_entry(1'b1, `HOST_SCRATCH_ADDR, 64'h0BAD_CAFE_0000_0077);
    add_entry(1'b0, `DRAM_BASE_ADDR + 32'h20, '0);
    add_entry(1'b0, `HOST_SCRATCH_ADDR, '0);
    add_entry(1'b1, `DRAM_BASE_ADDR + 32'h28, 64'h2222_3333_4444_5555);
    add_entry(1'b0, `DRAM_BASE_ADDR + 32'h28, '0);
    add_entry(1'b0, `HOST_FINISH_ADDR, '0);
    // Random mix over words 0 to 7 and scratch
    for (int i = 0; i < RAND_OPS; i++)
    begin
      r        = $random(seed);
      data     = {$random(seed), $random(seed)};
      off      = '0;
      off[5:3] = r[4:2];
      off[11]  = r[5];
      addr     = (r[1:0] == 2'b00) ? `HOST_SCRATCH_ADDR : `DRAM_BASE_ADDR + off;
      add_entry(r[6], addr, data);
    end
  endtask

  task automatic check_value(input mem_pkg::mem_data_t got, input mem_pkg::mem_data_t exp,
                             input string what);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic issue_commands();
    logic taken;
    @(negedge clk_i);
    // First command already waits at the port during config
    cmd_v_i    = 1'b1;
    cmd_we_i   = tbl[0].we;
    cmd_addr_i = tbl[0].addr;
    cmd_data_i = tbl[0].data;
    while (!cfg_done_o)
    begin
      #(ISSUE_SAMPLE);
      check_value(64'(cmd_ready_o), 64'd0, "cmd_ready_o before cfg_done_o");
      @(negedge clk_i);
    end
    check_value(64'(program_finish_o), 64'd0, "program_finish_o before any finish write");
    foreach (tbl[i])
    begin
      cmd_v_i    = 1'b1;
      cmd_we_i   = tbl[i].we;
      cmd_addr_i = tbl[i].addr;
      cmd_data_i = tbl[i].data;
      taken      = 1'b0;
      while (!taken)
      begin
        #(ISSUE_SAMPLE);
        taken = cmd_ready_o;
        @(negedge clk_i);
      end
      issued++;
    end
    cmd_v_i = 1'b0;
  endtask

  task automatic collect_responses();
    int n;
    n = 0;
    while (n < tbl.size())
    begin
      @(negedge clk_i);
      #(RESP_SAMPLE);
      if (resp_v_o && resp_ready_i)
      begin
        check_value(64'(n < issued), 64'd1, "response with no command outstanding");
        check_value(64'(resp_we_o), 64'(tbl[n].we), $sformatf("resp_we_o of entry %0d", n));
        check_value(resp_data_o, tbl[n].exp, $sformatf("resp_data_o of entry %0d", n));
        n++;
      end
    end
  endtask

  task automatic drive_ready();
    logic [31:0] r;
    forever
    begin
      @(negedge clk_i);
      r            = $random(seed);
      resp_ready_i = (r[1:0] != 2'b00);
    end
  endtask

  task automatic run_watchdog();
    int limit;
    limit = tbl.size() * (`DRAM_LATENCY + 20) + `RESET_DELAY + 3 +
            (`CFG_WORDS + 1) * (`DRAM_LATENCY + 20);
    repeat (limit) @(posedge clk_i);
    $display("Run timed out after %0d cycles with responses still missing", limit);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  endtask

  initial
  begin
    arst_n_i     = 1'b0;
    cmd_v_i      = 1'b0;
    cmd_we_i     = 1'b0;
    cmd_addr_i   = '0;
    cmd_data_i   = '0;
    resp_ready_i = 1'b0;
    issued       = 0;
    build_table();
    fork
      run_watchdog();
    join_none
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_value(64'(resp_v_o), 64'd0, "resp_v_o during reset");
    check_value(64'(cmd_ready_o), 64'd0, "cmd_ready_o during reset");
    check_value(64'(cfg_done_o), 64'd0, "cfg_done_o during reset");
    check_value(64'(program_finish_o), 64'd0, "program_finish_o during reset");
    arst_n_i = 1'b1;
    fork
      drive_ready();
    join_none
    fork
      issue_commands();
      collect_responses();
    join
    repeat (2) @(negedge clk_i);
    check_value(64'(resp_v_o), 64'd0, "resp_v_o after the last response");
    check_value(64'(program_finish_o), 64'd1, "program_finish_o after finish write");
    check_value(64'(cfg_done_o), 64'd1, "cfg_done_o at end of run");
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: verilog/cfg_loader.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module cfg_loader
  (
    input  logic       clk_i,
    input  logic       arst_n_i,
    mem_cmd_if.master  cmd,
    mem_resp_if.slave  resp,
    output logic       cfg_done_o
  );

  localparam int IDX_W = $clog2(`CFG_WORDS + 1);

  logic [`RESET_DELAY-1:0] delay_r;
  mem_pkg::loader_state_e  state_r;
  mem_pkg::loader_state_e  state_n;
  logic [IDX_W-1:0]        idx_r;
  logic                    last;

  // Ones shift in after reset release
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      delay_r <= '0;
    end
    else
    begin
      delay_r <= {delay_r[`RESET_DELAY-2:0], 1'b1};
    end
  end

  // Table of DRAM words, then one scratch write
  always_comb
  begin
    if (idx_r < IDX_W'(`CFG_WORDS))
    begin
      cmd.addr = `DRAM_BASE_ADDR + (mem_pkg::mem_addr_t'(idx_r) << 3);
      cmd.data = `CFG_PATTERN + mem_pkg::mem_data_t'(idx_r);
    end
    else
    begin
      cmd.addr = `HOST_SCRATCH_ADDR;
      cmd.data = `CFG_PATTERN;
    end
  end

  assign last = (idx_r == IDX_W'(`CFG_WORDS));

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      mem_pkg::WAIT_RESET:
        if (delay_r[`RESET_DELAY-1])
          state_n = mem_pkg::ISSUE;
      mem_pkg::ISSUE:
        if (cmd.yumi)
          state_n = mem_pkg::WAIT_RESP;
      mem_pkg::WAIT_RESP:
        if (resp.v)
          state_n = last ? mem_pkg::DONE : mem_pkg::ISSUE;
      default:
        state_n = mem_pkg::DONE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r <= mem_pkg::WAIT_RESET;
      idx_r   <= '0;
    end
    else
    begin
      state_r <= state_n;
      if ((state_r == mem_pkg::WAIT_RESP) && resp.v && !last)
      begin
        idx_r <= idx_r + IDX_W'(1);
      end
    end
  end

  assign cmd.v      = (state_r == mem_pkg::ISSUE);
  assign cmd.we     = 1'b1;
  assign resp.ready = (state_r == mem_pkg::WAIT_RESP);
  assign cfg_done_o = (state_r == mem_pkg::DONE);

endmodule

// File: verilog/dram_model.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module dram_model
  (
    input  logic       clk_i,
    input  logic       arst_n_i,
    mem_cmd_if.slave   cmd,
    mem_resp_if.master resp
  );

  localparam int LAT = `DRAM_LATENCY;

  mem_pkg::mem_data_t mem_q [`DRAM_WORDS];
  mem_pkg::mem_addr_t offset;
  mem_pkg::dram_idx_t idx;
  logic [LAT-1:0]     v_r;
  logic               we_r [LAT];
  mem_pkg::mem_data_t data_r [LAT];
  logic               stall;
  logic               accept;

  // Word index wraps modulo the depth
  assign offset = cmd.addr - `DRAM_BASE_ADDR;
  assign idx    = offset[3 +: `DRAM_IDX_WIDTH];

  // Whole pipe freezes while the head waits
  assign stall    = v_r[LAT-1] & ~resp.ready;
  assign accept   = cmd.v & ~stall;
  assign cmd.yumi = accept;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      v_r <= '0;
    end
    else if (!stall)
    begin
      v_r <= {v_r[LAT-2:0], accept};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept && cmd.we)
    begin
      mem_q[idx] <= cmd.data;
    end
    if (!stall)
    begin
      // Writes answer with zero data
      we_r[0]   <= cmd.we;
      data_r[0] <= cmd.we ? '0 : mem_q[idx];
      for (int s = 1; s < LAT; s++)
      begin
        we_r[s]   <= we_r[s-1];
        data_r[s] <= data_r[s-1];
      end
    end
  end

  assign resp.v    = v_r[LAT-1];
  assign resp.we   = we_r[LAT-1];
  assign resp.data = data_r[LAT-1];

endmodule

// File: verilog/host_mmio.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module host_mmio
  (
    input  logic       clk_i,
    input  logic       arst_n_i,
    mem_cmd_if.slave   cmd,
    mem_resp_if.master resp,
    output logic       program_finish_o
  );

  mem_pkg::mem_data_t scratch_r;
  logic               finish_r;
  logic               resp_v_r;
  logic               resp_we_r;
  mem_pkg::mem_data_t resp_data_r;
  mem_pkg::mem_data_t rd_data;
  logic               accept;

  // One response slot, reusable as it drains
  assign accept   = cmd.v & (~resp_v_r | resp.ready);
  assign cmd.yumi = accept;

  always_comb
  begin
    rd_data = '0;
    if (cmd.addr == `HOST_SCRATCH_ADDR)
    begin
      rd_data = scratch_r;
    end
    else if (cmd.addr == `HOST_FINISH_ADDR)
    begin
      rd_data = mem_pkg::mem_data_t'(finish_r);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      finish_r <= 1'b0;
      resp_v_r <= 1'b0;
    end
    else
    begin
      // Sticky once set
      if (accept && cmd.we && (cmd.addr == `HOST_FINISH_ADDR))
      begin
        finish_r <= 1'b1;
      end
      if (accept)
      begin
        resp_v_r <= 1'b1;
      end
      else if (resp.ready)
      begin
        resp_v_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept && cmd.we && (cmd.addr == `HOST_SCRATCH_ADDR))
    begin
      scratch_r <= cmd.data;
    end
    if (accept)
    begin
      resp_we_r   <= cmd.we;
      resp_data_r <= cmd.we ? '0 : rd_data;
    end
  end

  assign resp.v           = resp_v_r;
  assign resp.we          = resp_we_r;
  assign resp.data        = resp_data_r;
  assign program_finish_o = finish_r;

endmodule

// File: verilog/mem_harness_top.sv
`timescale 1ns/1ps

module mem_harness_top
  (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               cmd_v_i,
    input  logic               cmd_we_i,
    input  mem_pkg::mem_addr_t cmd_addr_i,
    input  mem_pkg::mem_data_t cmd_data_i,
    output logic               cmd_ready_o,
    output logic               resp_v_o,
    output logic               resp_we_o,
    output mem_pkg::mem_data_t resp_data_o,
    input  logic               resp_ready_i,
    output logic               cfg_done_o,
    output logic               program_finish_o
  );

  mem_cmd_if  cfg_cmd ();
  mem_resp_if cfg_resp ();
  mem_cmd_if  ext_cmd ();
  mem_cmd_if  host_cmd ();
  mem_resp_if host_resp ();
  mem_cmd_if  dram_cmd ();
  mem_resp_if dram_resp ();

  logic cfg_done;

  // External port, ready is the router's yumi
  assign ext_cmd.v    = cmd_v_i;
  assign ext_cmd.we   = cmd_we_i;
  assign ext_cmd.addr = cmd_addr_i;
  assign ext_cmd.data = cmd_data_i;
  assign cmd_ready_o  = ext_cmd.yumi;
  assign cfg_done_o   = cfg_done;

  cfg_loader u_cfg_loader
  (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .cmd        (cfg_cmd),
    .resp       (cfg_resp),
    .cfg_done_o (cfg_done)
  );

  mmio_router u_router
  (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cfg_done_i   (cfg_done),
    .cfg_cmd      (cfg_cmd),
    .cfg_resp     (cfg_resp),
    .ext_cmd      (ext_cmd),
    .resp_v_o     (resp_v_o),
    .resp_we_o    (resp_we_o),
    .resp_data_o  (resp_data_o),
    .resp_ready_i (resp_ready_i),
    .host_cmd     (host_cmd),
    .host_resp    (host_resp),
    .dram_cmd     (dram_cmd),
    .dram_resp    (dram_resp)
  );

  host_mmio u_host_mmio
  (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .cmd              (host_cmd),
    .resp             (host_resp),
    .program_finish_o (program_finish_o)
  );

  dram_model u_dram
  (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .cmd      (dram_cmd),
    .resp     (dram_resp)
  );

endmodule

// File: verilog/mem_if.sv
`timescale 1ns/1ps

// Command channel, valid/yumi
interface mem_cmd_if;

  logic               v;
  logic               yumi;
  logic               we;
  mem_pkg::mem_addr_t addr;
  mem_pkg::mem_data_t data;

  modport master
  (
    output v,
    output we,
    output addr,
    output data,
    input  yumi
  );

  modport slave
  (
    input  v,
    input  we,
    input  addr,
    input  data,
    output yumi
  );

endinterface

// Response channel, valid/ready
interface mem_resp_if;

  logic               v;
  logic               ready;
  logic               we;
  mem_pkg::mem_data_t data;

  modport master
  (
    output v,
    output we,
    output data,
    input  ready
  );

  modport slave
  (
    input  v,
    input  we,
    input  data,
    output ready
  );

endinterface

// File: verilog/mem_pkg.sv
`include "mem_macros.svh"

package mem_pkg;

  // Byte address and data word
  typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [`MEM_DATA_WIDTH-1:0] mem_data_t;

  // DRAM word index
  typedef logic [`DRAM_IDX_WIDTH-1:0] dram_idx_t;

  // Config loader sequence
  typedef enum logic [1:0]
  {
    WAIT_RESET = 2'd0,
    ISSUE      = 2'd1,
    WAIT_RESP  = 2'd2,
    DONE       = 2'd3
  } loader_state_e;

  // Target of the commands in flight
  typedef enum logic
  {
    TGT_HOST = 1'b0,
    TGT_DRAM = 1'b1
  } route_e;

endpackage

// File: verilog/mmio_router.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mmio_router
  (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               cfg_done_i,
    mem_cmd_if.slave           cfg_cmd,
    mem_resp_if.master         cfg_resp,
    mem_cmd_if.slave           ext_cmd,
    output logic               resp_v_o,
    output logic               resp_we_o,
    output mem_pkg::mem_data_t resp_data_o,
    input  logic               resp_ready_i,
    mem_cmd_if.master          host_cmd,
    mem_resp_if.slave          host_resp,
    mem_cmd_if.master          dram_cmd,
    mem_resp_if.slave          dram_resp
  );

  localparam int CNT_W = $clog2(`ORDER_DEPTH + 1);
  localparam int PTR_W = $clog2(`ORDER_DEPTH);

  logic               sel_v;
  logic               sel_we;
  mem_pkg::mem_addr_t sel_addr;
  mem_pkg::mem_data_t sel_data;
  mem_pkg::route_e    tgt;
  mem_pkg::route_e    route_r;
  logic [CNT_W-1:0]   cnt_r;
  logic [PTR_W-1:0]   wr_ptr_r;
  logic [PTR_W-1:0]   rd_ptr_r;
  logic               src_q [`ORDER_DEPTH];
  logic               can_issue;
  logic               accept;
  logic               tgt_v;
  logic               tgt_we;
  mem_pkg::mem_data_t tgt_data;
  logic               head_ext;
  logic               rsp_ready;
  logic               rsp_fire;

  // Loader owns the port until it is done
  assign sel_v    = cfg_done_i ? ext_cmd.v    : cfg_cmd.v;
  assign sel_we   = cfg_done_i ? ext_cmd.we   : cfg_cmd.we;
  assign sel_addr = cfg_done_i ? ext_cmd.addr : cfg_cmd.addr;
  assign sel_data = cfg_done_i ? ext_cmd.data : cfg_cmd.data;

  assign tgt = (sel_addr < `DRAM_BASE_ADDR) ? mem_pkg::TGT_HOST : mem_pkg::TGT_DRAM;

  // Switching target only once everything has drained
  assign can_issue = (cnt_r == '0) ||
                     ((tgt == route_r) && (cnt_r != CNT_W'(`ORDER_DEPTH)));

  assign host_cmd.v    = sel_v & can_issue & (tgt == mem_pkg::TGT_HOST);
  assign host_cmd.we   = sel_we;
  assign host_cmd.addr = sel_addr;
  assign host_cmd.data = sel_data;

  assign dram_cmd.v    = sel_v & can_issue & (tgt == mem_pkg::TGT_DRAM);
  assign dram_cmd.we   = sel_we;
  assign dram_cmd.addr = sel_addr;
  assign dram_cmd.data = sel_data;

  assign accept       = host_cmd.yumi | dram_cmd.yumi;
  assign cfg_cmd.yumi = accept & ~cfg_done_i;
  assign ext_cmd.yumi = accept & cfg_done_i;

  // Only the current target can have responses pending
  assign tgt_v    = (route_r == mem_pkg::TGT_HOST) ? host_resp.v    : dram_resp.v;
  assign tgt_we   = (route_r == mem_pkg::TGT_HOST) ? host_resp.we   : dram_resp.we;
  assign tgt_data = (route_r == mem_pkg::TGT_HOST) ? host_resp.data : dram_resp.data;

  assign head_ext = src_q[rd_ptr_r];

  assign resp_v_o    = tgt_v & head_ext;
  assign resp_we_o   = tgt_we;
  assign resp_data_o = tgt_data;

  assign cfg_resp.v    = tgt_v & ~head_ext;
  assign cfg_resp.we   = tgt_we;
  assign cfg_resp.data = tgt_data;

  assign rsp_ready       = head_ext ? resp_ready_i : cfg_resp.ready;
  assign host_resp.ready = (route_r == mem_pkg::TGT_HOST) & rsp_ready;
  assign dram_resp.ready = (route_r == mem_pkg::TGT_DRAM) & rsp_ready;
  assign rsp_fire        = tgt_v & rsp_ready;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      route_r  <= mem_pkg::TGT_HOST;
      cnt_r    <= '0;
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      for (int i = 0; i < `ORDER_DEPTH; i++)
      begin
        src_q[i] <= 1'b0;
      end
    end
    else
    begin
      if (accept)
      begin
        route_r         <= tgt;
        src_q[wr_ptr_r] <= cfg_done_i;
        wr_ptr_r        <= wr_ptr_r + PTR_W'(1);
      end
      if (rsp_fire)
      begin
        rd_ptr_r <= rd_ptr_r + PTR_W'(1);
      end
      cnt_r <= cnt_r + CNT_W'(accept) - CNT_W'(rsp_fire);
    end
  end

endmodule
